//--- ucode_pkg.sv
`default_nettype none

package ucode_pkg;

   localparam int ucode_aw  = 5;   // Microcode index width, 32 words
   localparam int operand_w = 16;  // Instruction operand width

   typedef enum logic [2:0] {
      op_ld,                       // Acc = operand
      op_add,                      // Acc = acc + operand
      op_sub,                      // Acc = acc - operand
      op_and,                      // Acc = acc & operand
      op_xor,                      // Acc = acc ^ operand
      op_shl,                      // Acc <<= operand[3:0]
      op_shr                       // Acc >>= operand[3:0]
   } opcode_e;

   typedef enum logic [2:0] {
      alu_pass,                    // Pass B
      alu_add,
      alu_sub,                     // Acc + ~B + carry in
      alu_and,
      alu_xor
   } alu_op_e;

   typedef enum logic [1:0] {
      sh_none,
      sh_left,
      sh_right
   } shift_e;

   typedef struct packed {
      opcode_e                opcode;
      logic [operand_w-1:0]   operand;
   } instr_t;

   // Control word, s_alu sits in the top bits
   typedef struct packed {
      alu_op_e                s_alu;      // ALU select
      logic                   s_carryin;  // Carry in, set for sub
      shift_e                 s_shift;    // Shifter mode, stalls while count nonzero
      logic                   ld_opnd;    // Load operand register B
      logic                   ld_cnt;     // Load shift counter
      logic                   we_acc;     // Accumulator write enable
      logic                   dispatch;   // Next index from opcode entry
      logic                   last;       // End of sequence
      logic [ucode_aw-1:0]    rinx;       // Next microcode index
   } ucode_word_t;

   // Entry points into the microcode
   localparam logic [ucode_aw-1:0] ent_ld  = 5'd1;
   localparam logic [ucode_aw-1:0] ent_add = 5'd3;
   localparam logic [ucode_aw-1:0] ent_sub = 5'd5;
   localparam logic [ucode_aw-1:0] ent_and = 5'd7;
   localparam logic [ucode_aw-1:0] ent_xor = 5'd9;
   localparam logic [ucode_aw-1:0] ent_shl = 5'd11;
   localparam logic [ucode_aw-1:0] ent_shr = 5'd14;
   localparam logic [ucode_aw-1:0] ent_nop = 5'd13;  // Bare last word of shl

   localparam ucode_word_t uw_nop = '{s_alu: alu_pass, s_carryin: 1'b0, s_shift: sh_none,
                                      ld_opnd: 1'b0, ld_cnt: 1'b0, we_acc: 1'b0,
                                      dispatch: 1'b0, last: 1'b0, rinx: '0};

   localparam ucode_word_t uw_idle = '{s_alu: alu_pass, s_carryin: 1'b0, s_shift: sh_none,
                                       ld_opnd: 1'b0, ld_cnt: 1'b0, we_acc: 1'b0,
                                       dispatch: 1'b1, last: 1'b0, rinx: '0};

   function automatic logic [ucode_aw-1:0] ucode_entry(input opcode_e op);
      case (op)
         op_ld:   return ent_ld;
         op_add:  return ent_add;
         op_sub:  return ent_sub;
         op_and:  return ent_and;
         op_xor:  return ent_xor;
         op_shl:  return ent_shl;
         op_shr:  return ent_shr;
         default: return ent_nop;  // Unknown code retires without effect
      endcase
   endfunction

endpackage

`default_nettype wire

//--- ucode_sequencer.sv
`default_nettype none

module ucode_sequencer #(
   parameter int data_w = 16
) (
   input  wire logic                              clk,
   input  wire logic                              rst_n,
   input  wire logic                              instr_valid,     // One-cycle strobe
   input  wire ucode_pkg::instr_t                 instr,
   input  wire ucode_pkg::ucode_word_t            uword,           // Current control word
   input  wire logic                              progress_ucode,  // Low while shifting
   output logic        [ucode_pkg::ucode_aw-1:0]  minx,            // Next microcode index
   output logic        [data_w-1:0]               opnd,            // Latched operand
   output logic                                   busy,
   output logic                                   done
);

   ucode_pkg::instr_t instr_q;  // Instruction in flight
   logic              accept;   // Strobe taken this edge
   logic              retire;   // Last word leaves this edge

   assign accept = instr_valid && !busy;  // Strobes while busy are dropped
   assign retire = busy && uword.last && progress_ucode;

   // Payload only, opcode is looked at while busy
   always_ff @(posedge clk) begin
      if (accept) begin
         instr_q <= instr;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         done <= 1'b0;
      end else begin
         done <= retire;  // Single pulse, result valid with it
         if (accept) begin
            busy <= 1'b1;
         end else if (retire) begin
            busy <= 1'b0;
         end
      end
   end

   // Idle word loops on itself until an instruction is in flight.
   // Index is frozen during a stall because the store holds uword.
   assign minx = (busy && uword.dispatch) ? ucode_pkg::ucode_entry(instr_q.opcode)
                                          : uword.rinx;

   assign opnd = instr_q.operand;  // Same width as data_w

endmodule

`default_nettype wire

//--- ucode_store.sv
`default_nettype none

module ucode_store #(
   parameter int no_ucodeopt = 0
) (
   input  wire logic                              clk,
   input  wire logic                              rst_n,
   input  wire logic  [ucode_pkg::ucode_aw-1:0]   minx,
   input  wire logic                              progress_ucode,  // Freeze word when low
   output ucode_pkg::ucode_word_t                 uword
);

   ucode_pkg::ucode_word_t rom_word;  // Word addressed by minx

   generate
      if (no_ucodeopt == 1) begin : g_flat
         // Full 16-bit words, fields as in ucode_word_t
         function automatic logic [$bits(ucode_pkg::ucode_word_t)-1:0] flat_rom(
            input logic [ucode_pkg::ucode_aw-1:0] idx
         );
            case (idx)
               5'd1:    return 16'h0202;  // ld: load B
               5'd2:    return 16'h00A0;  // Pass B, write, last
               5'd3:    return 16'h0204;  // add
               5'd4:    return 16'h20A0;
               5'd5:    return 16'h0206;  // sub
               5'd6:    return 16'h50A0;  // Carry in set
               5'd7:    return 16'h0208;  // and
               5'd8:    return 16'h60A0;
               5'd9:    return 16'h020A;  // xor
               5'd10:   return 16'h80A0;
               5'd11:   return 16'h010C;  // shl: load count
               5'd12:   return 16'h040D;  // Shift left
               5'd13:   return 16'h0020;  // Last
               5'd14:   return 16'h010F;  // shr: load count
               5'd15:   return 16'h0810;  // Shift right
               5'd16:   return 16'h0020;  // Last
               default: return 16'h0040;  // Idle, dispatch
            endcase
         endfunction

         assign rom_word = ucode_pkg::ucode_word_t'(flat_rom(minx));
      end else begin : g_compact
         typedef enum logic [3:0] {
            cl_idle, cl_load, cl_pass, cl_add, cl_sub, cl_and, cl_xor,
            cl_cnt, cl_shl, cl_shr, cl_last
         } cls_e;

         typedef struct packed {
            cls_e                           cls;   // Sequence class
            logic [ucode_pkg::ucode_aw-1:0] rinx;
         } centry_t;  // 9 bits

         function automatic centry_t compact_rom(input logic [ucode_pkg::ucode_aw-1:0] idx);
            case (idx)
               5'd1:    return '{cl_load, 5'd2};
               5'd2:    return '{cl_pass, 5'd0};
               5'd3:    return '{cl_load, 5'd4};
               5'd4:    return '{cl_add, 5'd0};
               5'd5:    return '{cl_load, 5'd6};
               5'd6:    return '{cl_sub, 5'd0};
               5'd7:    return '{cl_load, 5'd8};
               5'd8:    return '{cl_and, 5'd0};
               5'd9:    return '{cl_load, 5'd10};
               5'd10:   return '{cl_xor, 5'd0};
               5'd11:   return '{cl_cnt, 5'd12};
               5'd12:   return '{cl_shl, 5'd13};
               5'd13:   return '{cl_last, 5'd0};
               5'd14:   return '{cl_cnt, 5'd15};
               5'd15:   return '{cl_shr, 5'd16};
               5'd16:   return '{cl_last, 5'd0};
               default: return '{cl_idle, 5'd0};
            endcase
         endfunction

         centry_t ent;

         always_comb begin
            ent      = compact_rom(minx);
            rom_word = ucode_pkg::uw_nop;
            rom_word.rinx = ent.rinx;
            case (ent.cls)  // Enables
               cl_idle: rom_word.dispatch = 1'b1;
               cl_load: rom_word.ld_opnd  = 1'b1;
               cl_cnt:  rom_word.ld_cnt   = 1'b1;
               cl_shl:  rom_word.s_shift  = ucode_pkg::sh_left;
               cl_shr:  rom_word.s_shift  = ucode_pkg::sh_right;
               cl_last: rom_word.last     = 1'b1;
               default: begin  // ALU classes write and end
                  rom_word.we_acc = 1'b1;
                  rom_word.last   = 1'b1;
               end
            endcase
            case (ent.cls)  // ALU select
               cl_add:  rom_word.s_alu = ucode_pkg::alu_add;
               cl_sub: begin
                  rom_word.s_alu     = ucode_pkg::alu_sub;
                  rom_word.s_carryin = 1'b1;
               end
               cl_and:  rom_word.s_alu = ucode_pkg::alu_and;
               cl_xor:  rom_word.s_alu = ucode_pkg::alu_xor;
               default: rom_word.s_alu = ucode_pkg::alu_pass;
            endcase
         end
      end
   endgenerate

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         uword <= ucode_pkg::uw_idle;
      end else if (progress_ucode) begin  // Hold word while shifter busy
         uword <= rom_word;
      end
   end

endmodule

`default_nettype wire

//--- ucode_datapath.sv
`default_nettype none

module ucode_datapath #(
   parameter int data_w = 16
) (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire ucode_pkg::ucode_word_t  uword,           // Control fields
   input  wire logic   [data_w-1:0]     opnd,            // Operand from sequencer
   output logic                         progress_ucode,  // Low stalls the microcode
   output logic        [data_w-1:0]     result
);

   logic [data_w-1:0] opnd_b;     // Operand register B
   logic [3:0]        shift_cnt;  // Remaining shift steps
   logic [data_w-1:0] acc;        // Accumulator
   logic [data_w-1:0] alu_out;
   logic              shifting;   // Shift word present

   assign shifting       = (uword.s_shift != ucode_pkg::sh_none);
   assign progress_ucode = !(shifting && (shift_cnt != 4'd0));

   always_ff @(posedge clk) begin
      if (uword.ld_opnd) begin
         opnd_b <= opnd;
      end
   end

   always_comb begin
      case (uword.s_alu)
         ucode_pkg::alu_pass: alu_out = opnd_b;
         ucode_pkg::alu_add:  alu_out = acc + opnd_b;
         ucode_pkg::alu_sub:  alu_out = acc + ~opnd_b + data_w'(uword.s_carryin);
         ucode_pkg::alu_and:  alu_out = acc & opnd_b;
         ucode_pkg::alu_xor:  alu_out = acc ^ opnd_b;
         default:             alu_out = opnd_b;  // Unused selects
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         shift_cnt <= 4'd0;
      end else if (uword.ld_cnt) begin
         shift_cnt <= opnd[3:0];  // Shift amount
      end else if (!progress_ucode) begin
         shift_cnt <= shift_cnt - 4'd1;  // One step per stalled cycle
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (!progress_ucode) begin
         if (uword.s_shift == ucode_pkg::sh_left) begin
            acc <= {acc[data_w-2:0], 1'b0};  // Zero fill
         end else begin
            acc <= {1'b0, acc[data_w-1:1]};
         end
      end else if (uword.we_acc) begin
         acc <= alu_out;  // Wraps modulo 2**data_w
      end
   end

   assign result = acc;

endmodule

`default_nettype wire

//--- ucode_core.sv
`default_nettype none

module ucode_core #(
   parameter int data_w      = 16,  // Must equal ucode_pkg::operand_w
   parameter int no_ucodeopt = 0    // 1 selects the flat store
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 instr_valid,
   input  wire ucode_pkg::instr_t    instr,
   output logic                      busy,
   output logic                      done,
   output logic        [data_w-1:0]  result
);

   logic [ucode_pkg::ucode_aw-1:0] minx;            // Index into store
   ucode_pkg::ucode_word_t         uword;           // Registered control word
   logic                           progress_ucode;  // Stall from shifter
   logic [data_w-1:0]              opnd;            // Latched operand

   ucode_sequencer #(.data_w(data_w)) i_ucode_sequencer (
      .clk            (clk),
      .rst_n          (rst_n),
      .instr_valid    (instr_valid),
      .instr          (instr),
      .uword          (uword),
      .progress_ucode (progress_ucode),
      .minx           (minx),
      .opnd           (opnd),
      .busy           (busy),
      .done           (done)
   );

   ucode_store #(.no_ucodeopt(no_ucodeopt)) i_ucode_store (
      .clk            (clk),
      .rst_n          (rst_n),
      .minx           (minx),
      .progress_ucode (progress_ucode),
      .uword          (uword)
   );

   ucode_datapath #(.data_w(data_w)) i_ucode_datapath (
      .clk            (clk),
      .rst_n          (rst_n),
      .uword          (uword),
      .opnd           (opnd),
      .progress_ucode (progress_ucode),
      .result         (result)
   );

endmodule

`default_nettype wire

//--- ucode_core_chk.sv
`default_nettype none

module ucode_core_chk (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic instr_valid,
   input wire logic busy,
   input wire logic done,
   input wire logic progress_ucode
);

   timeunit 1ns;
   timeprecision 100ps;

   int assert_errs = 0;  // Failed assertion count

   a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else begin
         $error("done held longer than one cycle");
         assert_errs++;
      end

   a_done_busy : assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
      else begin
         $error("done without busy before it");
         assert_errs++;
      end

   a_no_stall_idle : assert property (@(posedge clk) disable iff (!rst_n)
                                      !busy |-> progress_ucode)
      else begin
         $error("microcode stalled while idle");
         assert_errs++;
      end

   a_busy_rise : assert property (@(posedge clk) disable iff (!rst_n)
                                  (instr_valid && !busy) |=> busy)
      else begin
         $error("busy did not follow accepted strobe");
         assert_errs++;
      end

endmodule

`default_nettype wire

//--- tb_ucode_core.sv
`default_nettype none

module tb_ucode_core;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int data_w       = 16;
   localparam int n_instr      = 300;
   localparam int reset_cycles = 16;
   // Worst case per instruction is 4+15 cycles, plus 2 idle edges between instructions
   localparam int limit_cycles = reset_cycles + n_instr * (4 + 15) + n_instr * 2 + 50;

   logic              clk;
   logic              rst_n;
   logic              instr_valid;
   ucode_pkg::instr_t instr;
   logic              busy;
   logic              done;
   logic [data_w-1:0] result;
   logic              busy_flat;    // Flat store build
   logic              done_flat;
   logic [data_w-1:0] result_flat;

   logic [data_w-1:0] model_acc;   // Reference accumulator
   logic [data_w-1:0] exp_result;  // Expected result at next done
   int                done_cnt;    // Done pulses of both cores
   int                issued;

   ucode_core #(.data_w(data_w), .no_ucodeopt(0)) i_ucode_core (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .busy        (busy),
      .done        (done),
      .result      (result)
   );

   // Same stimulus, flat microcode table
   ucode_core #(.data_w(data_w), .no_ucodeopt(1)) i_ucode_core_flat (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .busy        (busy_flat),
      .done        (done_flat),
      .result      (result_flat)
   );

   bind ucode_core ucode_core_chk i_ucode_core_chk (
      .clk            (clk),
      .rst_n          (rst_n),
      .instr_valid    (instr_valid),
      .busy           (busy),
      .done           (done),
      .progress_ucode (progress_ucode)
   );

   function automatic logic [data_w-1:0] ref_exec(input logic [data_w-1:0] acc,
                                                  input ucode_pkg::opcode_e op,
                                                  input logic [data_w-1:0] operand);
      case (op)
         ucode_pkg::op_ld:  return operand;
         ucode_pkg::op_add: return acc + operand;  // Wraps at data_w
         ucode_pkg::op_sub: return acc - operand;
         ucode_pkg::op_and: return acc & operand;
         ucode_pkg::op_xor: return acc ^ operand;
         ucode_pkg::op_shl: return acc << operand[3:0];  // Zero fill
         ucode_pkg::op_shr: return acc >> operand[3:0];
         default:           return acc;
      endcase
   endfunction

   // Failures of the bound checkers in both cores
   function automatic int count_assert_fails();
      return i_ucode_core.i_ucode_core_chk.assert_errs +
             i_ucode_core_flat.i_ucode_core_chk.assert_errs;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   // One instruction, optional dropped strobe while busy
   task automatic run_instr(input ucode_pkg::opcode_e op, input logic [data_w-1:0] operand,
                            input bit junk);
      int cycles;
      int exp_lat;
      @(posedge clk);
      #2;
      check_val("busy", busy, 0);
      check_val("busy_flat", busy_flat, 0);
      exp_lat    = (op == ucode_pkg::op_shl || op == ucode_pkg::op_shr) ? 4 + operand[3:0] : 3;
      exp_result = ref_exec(model_acc, op, operand);
      model_acc  = exp_result;
      instr_valid    = 1'b1;
      instr.opcode   = op;
      instr.operand  = operand;
      @(posedge clk);  // Strobe edge k
      #2;
      if (junk) begin  // Held into edge k+1 with a new payload, busy high
         instr.opcode  = ucode_pkg::opcode_e'($urandom_range(0, 6));
         instr.operand = data_w'($urandom);
      end else begin
         instr_valid = 1'b0;
      end
      cycles      = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
         if (instr_valid) begin
            #1;
            instr_valid = 1'b0;
         end
      end while (!done && !done_flat);
      issued++;
      check_val("done", done, 1);
      check_val("done_flat", done_flat, 1);
      check_val("done latency", cycles, exp_lat);
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // Result checker, sampled just after each edge
   initial begin
      done_cnt = 0;
      forever begin
         @(posedge clk);
         #1;
         if (done) begin
            done_cnt++;
            check_val("result", result, exp_result);
         end
         if (done_flat) begin
            done_cnt++;
            check_val("result_flat", result_flat, exp_result);
         end
         if (count_assert_fails() != 0) begin
            $display("a bound assertion on the handshake failed");
            $display("sim failed");
            $fatal(1);
         end
      end
   end

   initial begin
      #(limit_cycles * 40);
      $display("timeout: done never came within %0d cycles", limit_cycles);
      $display("sim failed");
      $fatal(1);
   end

   initial begin
      void'($urandom(67));
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      model_acc   = '0;
      exp_result  = '0;
      issued      = 0;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_val("busy", busy, 0);
      check_val("done", done, 0);
      check_val("result", result, 0);  // Accumulator cleared
      check_val("busy_flat", busy_flat, 0);
      check_val("done_flat", done_flat, 0);
      check_val("result_flat", result_flat, 0);
      run_instr(ucode_pkg::op_ld, data_w'($urandom), 1'b0);
      for (int i = 1; i < n_instr; i++) begin
         run_instr(ucode_pkg::opcode_e'($urandom_range(0, 6)), data_w'($urandom),
                   ($urandom_range(0, 3) == 0));
      end
      repeat (3) @(posedge clk);
      #1;
      if (done_cnt == 2 * issued && count_assert_fails() == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("done pulses %0d for %0d instructions on two cores, or assertions failed",
                  done_cnt, issued);
         $display("sim failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
ucode_pkg.sv
ucode_sequencer.sv
ucode_store.sv
ucode_datapath.sv
ucode_core.sv
ucode_core_chk.sv
tb_ucode_core.sv

//--- Bender.yml
package:
  name: ucode_core

sources:
  - ucode_pkg.sv
  - ucode_sequencer.sv
  - ucode_store.sv
  - ucode_datapath.sv
  - ucode_core.sv
  - target: test
    files:
      - ucode_core_chk.sv
      - tb_ucode_core.sv
